/* verilog.f */
+incdir+hdl
hdl/tx_pkg.sv
hdl/qp_sched.sv
hdl/sq_fetch.sv
hdl/qpc_lookup.sv
hdl/hold_stage.sv
hdl/pkt_desc_builder.sv
hdl/tx_engine.sv
tb/tb_tx_engine.sv

/* Makefile */
# tx_engine testbench with Verilator

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_tx_engine \
		-Mdir obj_dir -o sim_tx_engine
	./obj_dir/sim_tx_engine | tee /dev/stderr | grep "Simulation PASSED" > /dev/null

clean:
	rm -rf obj_dir

/* tb/tb_tx_engine.sv */
`include "tx_defs.svh"

module tb_tx_engine;
    import tx_pkg::*;

    localparam int NQ = `TX_NUM_QP;

    logic                      clk;
    logic                      rst;
    logic [NQ-1:0]             active;
    logic [`TX_AXI_ADDR_W-1:0] sq_base;
    logic [`TX_AXI_ADDR_W-1:0] axi_araddr;
    logic                      axi_arvalid;
    logic                      axi_arready;
    logic [`TX_AXI_DATA_W-1:0] axi_rdata;
    logic [1:0]                axi_rresp;
    logic                      axi_rvalid;
    logic                      axi_rready;
    logic                      qpc_req_valid;
    logic                      qpc_req_ready;
    qpn_t                      qpc_req_qpn;
    logic                      qpc_rsp_valid;
    qpc_t                      qpc_rsp;
    logic                      qpc_upd_valid;
    qpc_upd_t                  qpc_upd;
    logic                      desc_valid;
    logic                      desc_ready;
    pkt_desc_t                 desc;

    // context store written through the update port
    logic [`TX_PSN_W-1:0] psn_tab [NQ];
    logic [23:0]          dqpn_tab [NQ];
    logic [15:0]          pkey_tab [NQ];

    // expected send queue position and psn per qp
    int                   exp_idx [NQ];
    logic [`TX_PSN_W-1:0] exp_psn [NQ];
    int                   served [NQ];
    pkt_desc_t            desc_q [$];
    int                   check_errors;
    int                   timeouts;

    // handshakes seen at the last rising edge
    logic                      ar_hs;
    logic [`TX_AXI_ADDR_W-1:0] ar_hs_addr;
    logic                      r_hs;
    logic                      req_hs;
    qpn_t                      req_hs_qpn;
    logic                      upd_due;
    qpc_upd_t                  upd_exp;
    logic                      held_valid;
    pkt_desc_t                 held_desc;

    logic                      rd_busy;
    logic [`TX_AXI_ADDR_W-1:0] rd_addr;
    int                        ar_wait;
    int                        rd_wait;
    logic                      ctx_busy;
    qpn_t                      ctx_qpn;
    int                        req_wait;
    int                        rsp_wait;

    tx_engine UUT (
        .clk             (clk),
        .i_rst           (rst),
        .i_active        (active),
        .i_sq_base       (sq_base),
        .o_axi_araddr    (axi_araddr),
        .o_axi_arvalid   (axi_arvalid),
        .i_axi_arready   (axi_arready),
        .i_axi_rdata     (axi_rdata),
        .i_axi_rresp     (axi_rresp),
        .i_axi_rvalid    (axi_rvalid),
        .o_axi_rready    (axi_rready),
        .o_qpc_req_valid (qpc_req_valid),
        .i_qpc_req_ready (qpc_req_ready),
        .o_qpc_req_qpn   (qpc_req_qpn),
        .i_qpc_rsp_valid (qpc_rsp_valid),
        .i_qpc_rsp       (qpc_rsp),
        .o_qpc_upd_valid (qpc_upd_valid),
        .o_qpc_upd       (qpc_upd),
        .o_desc_valid    (desc_valid),
        .i_desc_ready    (desc_ready),
        .o_desc          (desc)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // host memory contents tied to the address
    function automatic wqe_t mem_wqe(logic [`TX_AXI_ADDR_W-1:0] addr);
        wqe_t w;
        w.wr_id  = addr;
        w.opcode = addr[31:24] ^ addr[10:3];
        w.length = addr[15:0] ^ addr[31:16] ^ 16'h0040;
        w.flags  = addr[23:16] ^ addr[7:0] ^ 8'h3c;
        return w;
    endfunction

    function automatic pkt_desc_t expect_desc(qpn_t q);
        logic [`TX_AXI_ADDR_W-1:0] addr;
        wqe_t                      w;
        pkt_desc_t                 d;
        addr = sq_base + 32'(q) * `TX_SQ_DEPTH * `TX_WQE_BYTES +
               32'(exp_idx[q]) * `TX_WQE_BYTES;
        w          = mem_wqe(addr);
        d.qpn      = q;
        d.dest_qpn = dqpn_tab[q];
        d.pkey     = pkey_tab[q];
        d.psn      = exp_psn[q];
        d.opcode   = w.opcode;
        d.length   = w.length;
        d.wr_id    = w.wr_id;
        d.flags    = w.flags;
        return d;
    endfunction

    task automatic check_desc(string name, pkt_desc_t got, pkt_desc_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
            check_errors++;
        end
    endtask

    task automatic check_upd(string name, qpc_upd_t got, qpc_upd_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
            check_errors++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED t=%0t %s: got %b expected %b", $time, name, got, exp);
            check_errors++;
        end
    endtask

    task automatic end_run();
        $display("errors: %0d failed checks, %0d timeouts", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    // AXI4-Lite read slave with random AR and R delays
    always @(negedge clk) begin
        if (rst) begin
            rd_busy     = 1'b0;
            axi_arready = 1'b0;
            axi_rvalid  = 1'b0;
            ar_wait     = 0;
        end else begin
            if (r_hs) begin
                rd_busy    = 1'b0;
                axi_rvalid = 1'b0;
            end
            if (ar_hs) begin
                rd_busy = 1'b1;
                rd_addr = ar_hs_addr;
                rd_wait = $urandom_range(3, 0);
            end
            axi_arready = 1'b0;
            if (axi_arvalid && !rd_busy) begin
                if (ar_wait == 0) begin
                    axi_arready = 1'b1;
                    ar_wait     = $urandom_range(3, 0);
                end else begin
                    ar_wait--;
                end
            end
            if (rd_busy && !axi_rvalid) begin
                if (rd_wait == 0) begin
                    axi_rvalid = 1'b1;
                    axi_rdata  = mem_wqe(rd_addr);
                end else begin
                    rd_wait--;
                end
            end
        end
    end

    // context store answering with a one cycle response pulse
    always @(negedge clk) begin
        if (rst) begin
            ctx_busy      = 1'b0;
            qpc_req_ready = 1'b0;
            qpc_rsp_valid = 1'b0;
            req_wait      = 0;
        end else begin
            if (qpc_rsp_valid) begin
                qpc_rsp_valid = 1'b0;
                ctx_busy      = 1'b0;
            end
            if (req_hs) begin
                ctx_busy = 1'b1;
                ctx_qpn  = req_hs_qpn;
                rsp_wait = $urandom_range(3, 0);
            end
            qpc_req_ready = 1'b0;
            if (qpc_req_valid && !ctx_busy) begin
                if (req_wait == 0) begin
                    qpc_req_ready = 1'b1;
                    req_wait      = $urandom_range(3, 0);
                end else begin
                    req_wait--;
                end
            end
            if (ctx_busy) begin
                if (rsp_wait == 0) begin
                    qpc_rsp_valid    = 1'b1;
                    qpc_rsp.psn      = psn_tab[ctx_qpn];
                    qpc_rsp.dest_qpn = dqpn_tab[ctx_qpn];
                    qpc_rsp.pkey     = pkey_tab[ctx_qpn];
                end else begin
                    rsp_wait--;
                end
            end
        end
    end

    always @(posedge clk) begin
        ar_hs      = axi_arvalid && axi_arready;
        ar_hs_addr = axi_araddr;
        r_hs       = axi_rvalid && axi_rready;
        req_hs     = qpc_req_valid && qpc_req_ready;
        req_hs_qpn = qpc_req_qpn;
        if (rst) begin
            upd_due    = 1'b0;
            held_valid = 1'b0;
        end else begin
            if (upd_due && !qpc_upd_valid) begin
                $display("t=%0t no context update after descriptor of QP %0d",
                         $time, upd_exp.qpn);
                check_errors++;
            end else if (!upd_due && qpc_upd_valid) begin
                $display("t=%0t context update for QP %0d without a descriptor",
                         $time, qpc_upd.qpn);
                check_errors++;
            end else if (upd_due) begin
                check_upd("o_qpc_upd", qpc_upd, upd_exp);
            end
            if (qpc_upd_valid) begin
                psn_tab[qpc_upd.qpn] = qpc_upd.psn;
            end
            // a stalled descriptor must not move
            if (held_valid) begin
                check_bit("o_desc_valid", desc_valid, 1'b1);
                check_desc("o_desc", desc, held_desc);
            end
            held_valid = desc_valid && !desc_ready;
            held_desc  = desc;
            upd_due    = desc_valid && desc_ready;
            if (upd_due) begin
                desc_q.push_back(desc);
                upd_exp.qpn = desc.qpn;
                upd_exp.psn = psn_tab[desc.qpn] + 24'd1;
            end
        end
    end

    task automatic wait_descs(int n, bit stall);
        int cycles;
        int stretch;
        cycles  = 0;
        stretch = 0;
        while (desc_q.size() < n && cycles < n * 80 + 200) begin
            @(negedge clk);
            cycles++;
            if (stall) begin
                if (stretch == 0) begin
                    desc_ready = !desc_ready;
                    stretch    = $urandom_range(6, 1);
                end else begin
                    stretch--;
                end
            end
        end
        if (desc_q.size() < n) begin
            $display("timeout: only %0d of %0d descriptors arrived", desc_q.size(), n);
            timeouts++;
            end_run();
        end
    endtask

    // empty once nothing has moved for a while
    task automatic wait_quiet();
        int cycles;
        int calm;
        cycles = 0;
        calm   = 0;
        while (calm < 16 && cycles < 1000) begin
            @(posedge clk);
            cycles++;
            if (axi_arvalid || rd_busy || qpc_req_valid || ctx_busy ||
                desc_valid || qpc_upd_valid) begin
                calm = 0;
            end else begin
                calm++;
            end
        end
        if (calm < 16) begin
            $display("timeout: the engine did not drain after traffic stopped");
            timeouts++;
            end_run();
        end
    endtask

    task automatic score_descs(logic [NQ-1:0] mask);
        pkt_desc_t got;
        while (desc_q.size() > 0) begin
            got = desc_q.pop_front();
            if (!mask[got.qpn]) begin
                $display("t=%0t descriptor for inactive QP %0d", $time, got.qpn);
                check_errors++;
            end else begin
                check_desc("o_desc", got, expect_desc(got.qpn));
                exp_idx[got.qpn] = (exp_idx[got.qpn] + 1) % `TX_SQ_DEPTH;
                exp_psn[got.qpn] = exp_psn[got.qpn] + 24'd1;
                served[got.qpn]++;
            end
        end
    endtask

    task automatic run_traffic(logic [NQ-1:0] mask, int n, bit stall);
        for (int q = 0; q < NQ; q++) begin
            served[q] = 0;
        end
        @(negedge clk);
        active     = mask;
        desc_ready = 1'b1;
        wait_descs(n, stall);
        active     = '0;
        desc_ready = 1'b1;
        wait_quiet();
        score_descs(mask);
    endtask

    task automatic test_single_qp();
        run_traffic(8'b0000_0100, 3, 1'b0);
    endtask

    task automatic test_multi_qp();
        logic [NQ-1:0] mask;
        mask = 8'b1011_0010;
        run_traffic(mask, 24, 1'b0);
        for (int q = 0; q < NQ; q++) begin
            if (mask[q] && served[q] == 0) begin
                $display("active QP %0d was never served", q);
                check_errors++;
            end
        end
    endtask

    task automatic test_backpressure();
        run_traffic(8'b0100_1001, 20, 1'b1);
    endtask

    task automatic test_psn_wrap();
        qpc_upd_t got;
        qpc_upd_t exp;
        @(negedge clk);
        psn_tab[6] = '1;
        exp_psn[6] = '1;
        run_traffic(8'b0100_0000, 3, 1'b0);
        got.qpn = 3'd6;
        got.psn = psn_tab[6];
        exp.qpn = 3'd6;
        exp.psn = exp_psn[6];
        check_upd("stored psn of QP 6", got, exp);
    endtask

    task automatic test_index_wrap();
        run_traffic(8'b0000_1000, 18, 1'b0);
    endtask

    task automatic test_reset_mid_run();
        @(negedge clk);
        active     = 8'b0011_0110;
        desc_ready = 1'b1;
        wait_descs(4, 1'b0);
        desc_ready = 1'b0;
        repeat (3) @(negedge clk);
        score_descs(8'b0011_0110);
        rst    = 1'b1;
        active = '0;
        @(negedge clk);
        check_bit("o_axi_arvalid", axi_arvalid, 1'b0);
        check_bit("o_axi_rready", axi_rready, 1'b0);
        check_bit("o_qpc_req_valid", qpc_req_valid, 1'b0);
        check_bit("o_desc_valid", desc_valid, 1'b0);
        check_bit("o_qpc_upd_valid", qpc_upd_valid, 1'b0);
        repeat (7) @(negedge clk);
        rst        = 1'b0;
        desc_ready = 1'b1;
        desc_q.delete();
        // consumer indices start over while psns stay in the context store
        for (int q = 0; q < NQ; q++) begin
            exp_idx[q] = 0;
        end
        run_traffic(8'b0000_0110, 6, 1'b0);
    endtask

    initial begin
        void'($urandom(32'h7d4c4277));
        rst           = 1'b1;
        active        = '0;
        sq_base       = 32'h0004_0000;
        axi_arready   = 1'b0;
        axi_rdata     = '0;
        axi_rresp     = 2'b00;
        axi_rvalid    = 1'b0;
        qpc_req_ready = 1'b0;
        qpc_rsp_valid = 1'b0;
        qpc_rsp       = '0;
        desc_ready    = 1'b1;
        ar_hs         = 1'b0;
        r_hs          = 1'b0;
        req_hs        = 1'b0;
        upd_due       = 1'b0;
        held_valid    = 1'b0;
        rd_busy       = 1'b0;
        ctx_busy      = 1'b0;
        ar_wait       = 0;
        req_wait      = 0;
        check_errors  = 0;
        timeouts      = 0;
        for (int q = 0; q < NQ; q++) begin
            psn_tab[q]  = 24'(q * 24'h01_1111 + 24'h10);
            dqpn_tab[q] = 24'h00_0100 + 24'(q);
            pkey_tab[q] = 16'hffff - 16'(q);
            exp_psn[q]  = psn_tab[q];
            exp_idx[q]  = 0;
            served[q]   = 0;
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;
        test_single_qp();
        test_multi_qp();
        test_backpressure();
        test_psn_wrap();
        test_index_wrap();
        test_reset_mid_run();
        end_run();
    end

endmodule

/* hdl/tx_engine.sv */
`include "tx_defs.svh"

module tx_engine (
    input  logic                      clk,
    input  logic                      i_rst,
    input  logic [`TX_NUM_QP-1:0]     i_active,
    input  logic [`TX_AXI_ADDR_W-1:0] i_sq_base,
    // wqe read master
    output logic [`TX_AXI_ADDR_W-1:0] o_axi_araddr,
    output logic                      o_axi_arvalid,
    input  logic                      i_axi_arready,
    input  logic [`TX_AXI_DATA_W-1:0] i_axi_rdata,
    input  logic [1:0]                i_axi_rresp,
    input  logic                      i_axi_rvalid,
    output logic                      o_axi_rready,
    // qp context lookup
    output logic                      o_qpc_req_valid,
    input  logic                      i_qpc_req_ready,
    output tx_pkg::qpn_t              o_qpc_req_qpn,
    input  logic                      i_qpc_rsp_valid,
    input  tx_pkg::qpc_t              i_qpc_rsp,
    // qp context update
    output logic                      o_qpc_upd_valid,
    output tx_pkg::qpc_upd_t          o_qpc_upd,
    // descriptor out
    output logic                      o_desc_valid,
    input  logic                      i_desc_ready,
    output tx_pkg::pkt_desc_t         o_desc
);
    import tx_pkg::*;

    logic issue;
    qpn_t issue_qpn;
    logic fetch_idle;
    logic lookup_idle;

    logic wqe_valid, wqe_ready;
    wqe_t wqe;
    logic wqe_h_valid, wqe_h_ready;
    wqe_t wqe_h;

    logic ctx_valid, ctx_ready;
    ctx_t ctx;
    logic ctx_h_valid, ctx_h_ready;
    ctx_t ctx_h;

    qp_sched u_qp_sched (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_active      (i_active),
        .i_fetch_idle  (fetch_idle),
        .i_lookup_idle (lookup_idle),
        .i_done        (o_qpc_upd_valid),
        .i_done_qpn    (o_qpc_upd.qpn),
        .o_issue       (issue),
        .o_issue_qpn   (issue_qpn)
    );

    sq_fetch u_sq_fetch (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_issue       (issue),
        .i_issue_qpn   (issue_qpn),
        .i_sq_base     (i_sq_base),
        .i_axi_arready (i_axi_arready),
        .i_axi_rdata   (i_axi_rdata),
        .i_axi_rresp   (i_axi_rresp),
        .i_axi_rvalid  (i_axi_rvalid),
        .i_out_ready   (wqe_ready),
        .o_idle        (fetch_idle),
        .o_axi_araddr  (o_axi_araddr),
        .o_axi_arvalid (o_axi_arvalid),
        .o_axi_rready  (o_axi_rready),
        .o_wqe_valid   (wqe_valid),
        .o_wqe         (wqe)
    );

    qpc_lookup u_qpc_lookup (
        .clk             (clk),
        .i_rst           (i_rst),
        .i_issue         (issue),
        .i_issue_qpn     (issue_qpn),
        .i_qpc_req_ready (i_qpc_req_ready),
        .i_qpc_rsp_valid (i_qpc_rsp_valid),
        .i_qpc_rsp       (i_qpc_rsp),
        .i_out_ready     (ctx_ready),
        .o_idle          (lookup_idle),
        .o_qpc_req_valid (o_qpc_req_valid),
        .o_qpc_req_qpn   (o_qpc_req_qpn),
        .o_ctx_valid     (ctx_valid),
        .o_ctx           (ctx)
    );

    hold_stage #(.payload_t(wqe_t)) u_wqe_hold (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_valid (wqe_valid),
        .i_data  (wqe),
        .i_ready (wqe_h_ready),
        .o_ready (wqe_ready),
        .o_valid (wqe_h_valid),
        .o_data  (wqe_h)
    );

    hold_stage #(.payload_t(ctx_t)) u_ctx_hold (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_valid (ctx_valid),
        .i_data  (ctx),
        .i_ready (ctx_h_ready),
        .o_ready (ctx_ready),
        .o_valid (ctx_h_valid),
        .o_data  (ctx_h)
    );

    pkt_desc_builder u_pkt_desc_builder (
        .clk             (clk),
        .i_rst           (i_rst),
        .i_wqe_valid     (wqe_h_valid),
        .i_wqe           (wqe_h),
        .i_ctx_valid     (ctx_h_valid),
        .i_ctx           (ctx_h.qpc),
        .i_qpn           (ctx_h.qpn),
        .i_desc_ready    (i_desc_ready),
        .o_wqe_ready     (wqe_h_ready),
        .o_ctx_ready     (ctx_h_ready),
        .o_desc_valid    (o_desc_valid),
        .o_desc          (o_desc),
        .o_qpc_upd_valid (o_qpc_upd_valid),
        .o_qpc_upd       (o_qpc_upd)
    );

endmodule

/* hdl/pkt_desc_builder.sv */
module pkt_desc_builder (
    input  logic              clk,
    input  logic              i_rst,
    input  logic              i_wqe_valid,
    input  tx_pkg::wqe_t      i_wqe,
    input  logic              i_ctx_valid,
    input  tx_pkg::qpc_t      i_ctx,
    input  tx_pkg::qpn_t      i_qpn,
    input  logic              i_desc_ready,
    output logic              o_wqe_ready,
    output logic              o_ctx_ready,
    output logic              o_desc_valid,
    output tx_pkg::pkt_desc_t o_desc,
    output logic              o_qpc_upd_valid,
    output tx_pkg::qpc_upd_t  o_qpc_upd
);
    import tx_pkg::*;

    logic join_go;
    logic desc_xfer;

    // both halves leave together into a free or draining slot
    assign join_go     = i_wqe_valid && i_ctx_valid && (!o_desc_valid || i_desc_ready);
    assign o_wqe_ready = join_go;
    assign o_ctx_ready = join_go;
    assign desc_xfer   = o_desc_valid && i_desc_ready;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_desc_valid    <= 1'b0;
            o_qpc_upd_valid <= 1'b0;
        end else begin
            if (join_go) begin
                o_desc_valid <= 1'b1;
            end else if (desc_xfer) begin
                o_desc_valid <= 1'b0;
            end
            o_qpc_upd_valid <= desc_xfer;
        end
    end

    always_ff @(posedge clk) begin
        if (join_go) begin
            o_desc.qpn      <= i_qpn;
            o_desc.dest_qpn <= i_ctx.dest_qpn;
            o_desc.pkey     <= i_ctx.pkey;
            o_desc.psn      <= i_ctx.psn;
            o_desc.opcode   <= i_wqe.opcode;
            o_desc.length   <= i_wqe.length;
            o_desc.wr_id    <= i_wqe.wr_id;
            o_desc.flags    <= i_wqe.flags;
        end
        // next psn wraps at the field width
        if (desc_xfer) begin
            o_qpc_upd.qpn <= o_desc.qpn;
            o_qpc_upd.psn <= o_desc.psn + 1'b1;
        end
    end

endmodule

/* hdl/hold_stage.sv */
module hold_stage #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     i_rst,
    input  logic     i_valid,
    input  payload_t i_data,
    input  logic     i_ready,
    output logic     o_ready,
    output logic     o_valid,
    output payload_t o_data
);

    logic valid_q;

    // accepts while empty or while the held entry leaves
    assign o_ready = !valid_q || i_ready;
    assign o_valid = valid_q;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            valid_q <= 1'b0;
        end else if (o_ready) begin
            valid_q <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (o_ready && i_valid) begin
            o_data <= i_data;
        end
    end

endmodule

/* hdl/qpc_lookup.sv */
module qpc_lookup (
    input  logic         clk,
    input  logic         i_rst,
    input  logic         i_issue,
    input  tx_pkg::qpn_t i_issue_qpn,
    input  logic         i_qpc_req_ready,
    input  logic         i_qpc_rsp_valid,
    input  tx_pkg::qpc_t i_qpc_rsp,
    input  logic         i_out_ready,
    output logic         o_idle,
    output logic         o_qpc_req_valid,
    output tx_pkg::qpn_t o_qpc_req_qpn,
    output logic         o_ctx_valid,
    output tx_pkg::ctx_t o_ctx
);
    import tx_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT,
        S_HAVE
    } state_t;

    state_t state;
    qpc_t   rsp_q;
    logic   rsp_now;

    // response parked while downstream is full
    assign rsp_now         = (state == S_WAIT) && i_qpc_rsp_valid;
    assign o_idle          = (state == S_IDLE);
    assign o_qpc_req_valid = (state == S_REQ);
    assign o_ctx_valid     = rsp_now || (state == S_HAVE);
    assign o_ctx.qpn       = o_qpc_req_qpn;
    assign o_ctx.qpc       = (state == S_HAVE) ? rsp_q : i_qpc_rsp;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: if (i_issue) state <= S_REQ;
                S_REQ:  if (i_qpc_req_ready) state <= S_WAIT;
                S_WAIT: if (i_qpc_rsp_valid) state <= i_out_ready ? S_IDLE : S_HAVE;
                S_HAVE: if (i_out_ready) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_idle && i_issue) begin
            o_qpc_req_qpn <= i_issue_qpn;
        end
        if (rsp_now) begin
            rsp_q <= i_qpc_rsp;
        end
    end

endmodule

/* hdl/sq_fetch.sv */
`include "tx_defs.svh"

module sq_fetch (
    input  logic                      clk,
    input  logic                      i_rst,
    input  logic                      i_issue,
    input  tx_pkg::qpn_t              i_issue_qpn,
    input  logic [`TX_AXI_ADDR_W-1:0] i_sq_base,
    input  logic                      i_axi_arready,
    input  logic [`TX_AXI_DATA_W-1:0] i_axi_rdata,
    input  logic [1:0]                i_axi_rresp,
    input  logic                      i_axi_rvalid,
    input  logic                      i_out_ready,
    output logic                      o_idle,
    output logic [`TX_AXI_ADDR_W-1:0] o_axi_araddr,
    output logic                      o_axi_arvalid,
    output logic                      o_axi_rready,
    output logic                      o_wqe_valid,
    output tx_pkg::wqe_t              o_wqe
);
    import tx_pkg::*;

    localparam int AW = `TX_AXI_ADDR_W;

    typedef enum logic [1:0] {
        S_IDLE,
        S_AR,
        S_R
    } state_t;

    state_t                  state;
    qpn_t                    qpn_q;
    logic [`TX_SQ_IDX_W-1:0] sq_idx [`TX_NUM_QP];
    logic                    r_done;

    assign o_idle        = (state == S_IDLE);
    assign o_axi_arvalid = (state == S_AR);
    // R stalls on the hold stage
    assign o_axi_rready  = (state == S_R) && i_out_ready;
    assign o_wqe_valid   = (state == S_R) && i_axi_rvalid;
    // rresp is ignored
    assign o_wqe         = wqe_t'(i_axi_rdata);
    assign r_done        = o_axi_rready && i_axi_rvalid;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state <= S_IDLE;
            for (int q = 0; q < `TX_NUM_QP; q++) begin
                sq_idx[q] <= '0;
            end
        end else begin
            case (state)
                S_IDLE: if (i_issue) state <= S_AR;
                S_AR:   if (i_axi_arready) state <= S_R;
                S_R: begin
                    if (r_done) begin
                        state <= S_IDLE;
                        if (sq_idx[qpn_q] == `TX_SQ_IDX_W'(`TX_SQ_DEPTH - 1)) begin
                            sq_idx[qpn_q] <= '0;
                        end else begin
                            sq_idx[qpn_q] <= sq_idx[qpn_q] + 1'b1;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // base + qpn * depth * 8 + index * 8
    always_ff @(posedge clk) begin
        if (o_idle && i_issue) begin
            qpn_q        <= i_issue_qpn;
            o_axi_araddr <= i_sq_base + (AW'(i_issue_qpn) * `TX_SQ_DEPTH +
                            AW'(sq_idx[i_issue_qpn])) * `TX_WQE_BYTES;
        end
    end

endmodule

/* hdl/qp_sched.sv */
`include "tx_defs.svh"

module qp_sched (
    input  logic                  clk,
    input  logic                  i_rst,
    input  logic [`TX_NUM_QP-1:0] i_active,
    input  logic                  i_fetch_idle,
    input  logic                  i_lookup_idle,
    input  logic                  i_done,
    input  tx_pkg::qpn_t          i_done_qpn,
    output logic                  o_issue,
    output tx_pkg::qpn_t          o_issue_qpn
);
    import tx_pkg::*;

    logic [`TX_NUM_QP-1:0] in_flight;
    qpn_t                  last_grant;
    logic                  pick_valid;
    qpn_t                  pick_qpn;
    logic                  cand_valid;
    qpn_t                  cand_qpn;
    logic                  cand_go;

    // first qp after the last grant that has work and is not in flight
    always_comb begin
        int idx;
        pick_valid = 1'b0;
        pick_qpn   = '0;
        for (int k = 1; k <= `TX_NUM_QP; k++) begin
            idx = (int'(last_grant) + k) % `TX_NUM_QP;
            if (!pick_valid && i_active[idx] && !in_flight[idx]) begin
                pick_valid = 1'b1;
                pick_qpn   = qpn_t'(idx);
            end
        end
    end

    // recheck the registered choice against the current mask
    assign cand_go = cand_valid && !o_issue && i_fetch_idle && i_lookup_idle &&
                     i_active[cand_qpn] && !in_flight[cand_qpn];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            cand_valid <= 1'b0;
            o_issue    <= 1'b0;
            in_flight  <= '0;
            last_grant <= qpn_t'(`TX_NUM_QP - 1);
        end else begin
            cand_valid <= pick_valid;
            o_issue    <= cand_go;
            if (cand_go) begin
                last_grant <= cand_qpn;
            end
            if (o_issue) begin
                in_flight[o_issue_qpn] <= 1'b1;
            end
            if (i_done) begin
                in_flight[i_done_qpn] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        cand_qpn <= pick_qpn;
        if (cand_go) begin
            o_issue_qpn <= cand_qpn;
        end
    end

endmodule

/* hdl/tx_pkg.sv */
`include "tx_defs.svh"

package tx_pkg;

    typedef logic [`TX_QPN_W-1:0] qpn_t;

    // one send queue slot in a single 64-bit beat
    typedef struct packed {
        logic [31:0] wr_id;
        logic [7:0]  opcode;
        logic [15:0] length;
        logic [7:0]  flags;
    } wqe_t;

    typedef struct packed {
        logic [`TX_PSN_W-1:0] psn;
        logic [23:0]          dest_qpn;
        logic [15:0]          pkey;
    } qpc_t;

    typedef struct packed {
        qpn_t                 qpn;
        logic [`TX_PSN_W-1:0] psn;
    } qpc_upd_t;

    // context tagged with the qp it was looked up for
    typedef struct packed {
        qpn_t qpn;
        qpc_t qpc;
    } ctx_t;

    typedef struct packed {
        qpn_t                 qpn;
        logic [23:0]          dest_qpn;
        logic [15:0]          pkey;
        logic [`TX_PSN_W-1:0] psn;
        logic [7:0]           opcode;
        logic [15:0]          length;
        logic [31:0]          wr_id;
        logic [7:0]           flags;
    } pkt_desc_t;

endpackage

/* hdl/tx_defs.svh */
`ifndef TX_DEFS_SVH
`define TX_DEFS_SVH

// queue pair space
`define TX_NUM_QP       8
`define TX_QPN_W        3

// send queue geometry
`define TX_SQ_DEPTH     16
`define TX_SQ_IDX_W     4
`define TX_WQE_BYTES    8

// host read channel
`define TX_AXI_ADDR_W   32
`define TX_AXI_DATA_W   64

// transport
`define TX_PSN_W        24

`endif
